// File: rx_front.f
+incdir+src
src/rx_front_pkg.sv
src/rx_sample_select.sv
src/rx_gain_lane.sv
src/rx_sample_align.sv
src/rx_byte_packer.sv
src/rx_pkt_status.sv
src/rx_front.sv
bench/rx_front_clkgen.sv
bench/rx_front_checker.sv
bench/rx_front_asserts.sv
bench/rx_front_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rx_front_tb -f rx_front.f -o Vrx_front_tb

status=0
./obj_dir/Vrx_front_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: bench/rx_front_tb.sv
// rx_front_tb: testbench top for the receive front end with stimulus, watchdog and report
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_front_tb;

    localparam int BURST_LEN   = 16;
    localparam int ADC_BURSTS  = 8;
    localparam int LOOP_BURSTS = 4;
    localparam int NUM_FRAMES  = 12;
    localparam int MAX_FRAME   = 20;
    localparam int NUM_FCS     = 40;
    // worst case cycles per phase, gaps and drains included
    localparam int SAMPLE_CYC  = (ADC_BURSTS + LOOP_BURSTS + 2) * (BURST_LEN + 12);
    localparam int PACK_CYC    = NUM_FRAMES * (2 * MAX_FRAME + 8);
    localparam int STATUS_CYC  = NUM_FCS * 5;
    localparam int TIMEOUT_NS  = (SAMPLE_CYC + PACK_CYC + STATUS_CYC + 200) * 8;

    logic                       clk;
    logic                       reset;
    rx_front_pkg::adc_word_u    adc_data;
    logic                       adc_valid;
    rx_front_pkg::iq_sample_t   tx_iq0;
    rx_front_pkg::iq_sample_t   tx_iq1;
    logic                       tx_iq_valid;
    logic                       ant_swap;
    logic                       mute_ant0;
    logic                       loopback_en;
    logic [`GAIN_WIDTH-1:0]     bb_gain;
    logic                       strobe_delay_sel;
    logic                       intr_on_any_fcs;
    logic [2*`IQ_WIDTH-1:0]     sample0;
    logic [2*`IQ_WIDTH-1:0]     sample1;
    logic                       sample_strobe;
    logic [7:0]                 byte_in;
    logic                       byte_in_strobe;
    logic                       pkt_header_valid_strobe;
    logic                       fcs_in_strobe;
    logic                       fcs_ok;
    logic [`PKT_WORD_WIDTH-1:0] word_out;
    logic                       word_strobe;
    logic                       rx_pkt_intr;
    logic [`PKT_CNT_WIDTH-1:0]  rx_pkt_sn;
    logic [`PKT_CNT_WIDTH-1:0]  good_count;
    logic [`PKT_CNT_WIDTH-1:0]  bad_count;
    logic                       fcs_ok_led;
    int                         pending;
    int                         checks;
    int                         errors;
    int                         last_checks;
    int                         last_errors;
    int                         seed = 5;

    rx_front_clkgen clkgen (.clk(clk), .reset(reset));

    rx_front uut (.*);

    rx_front_checker chk (.*);

    task automatic send_samples(input int n, input logic dense);
        logic [31:0] rnd;
        logic        v;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            rnd = $random(seed);
            v = dense | (rnd[1:0] != 2'b00);
            adc_data.raw = {$random(seed), $random(seed)};
            tx_iq0 = $random(seed);
            tx_iq1 = $random(seed);
            // the unused source toggles too and must not reach the lanes
            adc_valid = loopback_en ? rnd[2] : v;
            tx_iq_valid = loopback_en ? v : rnd[2];
        end
        @(negedge clk);
        adc_valid = 1'b0;
        tx_iq_valid = 1'b0;
    endtask

    // wait for every expected output, then let the delay stage empty
    task automatic drain();
        while (pending != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic send_frame(input int len, input logic ok, input int header_at);
        logic [31:0] rnd;
        pkt_header_valid_strobe = 1'b1;
        @(negedge clk);
        pkt_header_valid_strobe = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            if (i == header_at)
            begin
                // header mid word drops the collected bytes
                pkt_header_valid_strobe = 1'b1;
                @(negedge clk);
                pkt_header_valid_strobe = 1'b0;
            end
            rnd = $random(seed);
            byte_in = rnd[7:0];
            byte_in_strobe = 1'b1;
            @(negedge clk);
            byte_in_strobe = 1'b0;
            if (rnd[8])
                @(negedge clk);
        end
        send_fcs(ok, 2);
    endtask

    task automatic send_fcs(input logic ok, input int gap);
        fcs_ok = ok;
        fcs_in_strobe = 1'b1;
        @(negedge clk);
        fcs_in_strobe = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, checks - last_checks,
                 errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial
    begin : stimulus
        logic [31:0] rnd;
        int          len;
        adc_data.raw = '0;
        adc_valid = 1'b0;
        tx_iq0 = '0;
        tx_iq1 = '0;
        tx_iq_valid = 1'b0;
        ant_swap = 1'b0;
        mute_ant0 = 1'b0;
        loopback_en = 1'b0;
        bb_gain = '0;
        strobe_delay_sel = 1'b0;
        intr_on_any_fcs = 1'b0;
        byte_in = '0;
        byte_in_strobe = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        fcs_in_strobe = 1'b0;
        fcs_ok = 1'b0;
        @(negedge reset);
        @(negedge clk);

        // bit 2 of the burst index forces the largest shift
        for (int c = 0; c < ADC_BURSTS; c++)
        begin
            rnd = $random(seed);
            ant_swap = c[0];
            mute_ant0 = c[1];
            bb_gain = c[2] ? 3'd7 : rnd[2:0];
            send_samples(BURST_LEN, 1'b0);
            drain();
        end
        finish_test("adc_samples");

        loopback_en = 1'b1;
        for (int c = 0; c < LOOP_BURSTS; c++)
        begin
            rnd = $random(seed);
            ant_swap = c[0];
            mute_ant0 = c[1];
            bb_gain = rnd[2:0];
            send_samples(BURST_LEN, 1'b0);
            drain();
        end
        loopback_en = 1'b0;
        finish_test("loopback");

        for (int d = 0; d < 2; d++)
        begin
            strobe_delay_sel = d[0];
            send_samples(BURST_LEN, 1'b1);
            drain();
        end
        strobe_delay_sel = 1'b0;
        finish_test("strobe_latency");

        // frame 0 ends on a word boundary, frame 2 gets a header after 3 bytes
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            rnd = $random(seed);
            len = (f == 0) ? 16 : (f == 2) ? 12 : 1 + int'(rnd[15:8] % MAX_FRAME);
            send_frame(len, rnd[0], (f == 2) ? 3 : -1);
        end
        drain();
        finish_test("byte_packing");

        for (int n = 0; n < NUM_FCS; n++)
        begin
            rnd = $random(seed);
            intr_on_any_fcs = (n >= NUM_FCS / 2);
            send_fcs(rnd[0], 1 + int'(rnd[2:1]));
        end
        drain();
        finish_test("fcs_status");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: outputs still outstanding after %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/rx_front_asserts.sv
// rx_front_asserts: interrupt, flush and reset properties bound to rx_front
`timescale 1ns/1ps

module rx_front_asserts (
    input logic clk,
    input logic reset,
    input logic rx_pkt_intr,
    input logic word_strobe,
    input logic byte_in_strobe,
    input logic pkt_header_valid_strobe,
    input logic fcs_in_strobe,
    input logic sample_strobe
);

    logic [2:0] pend_bytes;

    // bytes in the current word, wraps at a full word
    always @(posedge clk)
    begin
        if (reset || pkt_header_valid_strobe || fcs_in_strobe)
            pend_bytes <= 3'd0;
        else if (byte_in_strobe)
            pend_bytes <= pend_bytes + 3'd1;
    end

    intr_single: assert property (@(posedge clk) disable iff (reset)
        rx_pkt_intr |=> !rx_pkt_intr)
        else $error("rx_pkt_intr high for two cycles");

    no_empty_flush: assert property (@(posedge clk) disable iff (reset)
        fcs_in_strobe && !byte_in_strobe && pend_bytes == 3'd0 |=> !word_strobe)
        else $error("word_strobe after a frame check with no pending bytes");

    strobe_in_reset: assert property (@(posedge clk) reset |=> !sample_strobe)
        else $error("sample_strobe high during reset");

endmodule

bind rx_front rx_front_asserts u_asserts (
    .clk                     (clk),
    .reset                   (reset),
    .rx_pkt_intr             (rx_pkt_intr),
    .word_strobe             (word_strobe),
    .byte_in_strobe          (byte_in_strobe),
    .pkt_header_valid_strobe (pkt_header_valid_strobe),
    .fcs_in_strobe           (fcs_in_strobe),
    .sample_strobe           (sample_strobe)
);

// File: bench/rx_front_checker.sv
// rx_front_checker: reference model of rx_front outputs and comparison against the DUT
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_front_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  rx_front_pkg::adc_word_u    adc_data,
    input  logic                       adc_valid,
    input  rx_front_pkg::iq_sample_t   tx_iq0,
    input  rx_front_pkg::iq_sample_t   tx_iq1,
    input  logic                       tx_iq_valid,
    input  logic                       ant_swap,
    input  logic                       mute_ant0,
    input  logic                       loopback_en,
    input  logic [`GAIN_WIDTH-1:0]     bb_gain,
    input  logic                       strobe_delay_sel,
    input  logic                       intr_on_any_fcs,
    input  logic [2*`IQ_WIDTH-1:0]     sample0,
    input  logic [2*`IQ_WIDTH-1:0]     sample1,
    input  logic                       sample_strobe,
    input  logic [7:0]                 byte_in,
    input  logic                       byte_in_strobe,
    input  logic                       pkt_header_valid_strobe,
    input  logic                       fcs_in_strobe,
    input  logic                       fcs_ok,
    input  logic [`PKT_WORD_WIDTH-1:0] word_out,
    input  logic                       word_strobe,
    input  logic                       rx_pkt_intr,
    input  logic [`PKT_CNT_WIDTH-1:0]  rx_pkt_sn,
    input  logic [`PKT_CNT_WIDTH-1:0]  good_count,
    input  logic [`PKT_CNT_WIDTH-1:0]  bad_count,
    input  logic                       fcs_ok_led,
    output int                         pending,
    output int                         checks,
    output int                         errors
);

    logic [63:0] exp_samples[$];
    int          sample_cyc[$];
    logic [63:0] exp_words[$];
    int          word_cyc[$];
    logic [63:0] word_acc;
    int          nbytes;
    int          cyc;
    logic        exp_intr;
    logic [15:0] exp_sn;
    logic [15:0] exp_good;
    logic [15:0] exp_bad;
    logic        exp_led;

    // shift by multiplying, then clip to the signed 16-bit range
    function automatic logic [15:0] sat_gain(input logic [15:0] x, input int g);
        int v;
        v = int'($signed(x)) * (1 << g);
        if (v > 32767)
            v = 32767;
        else if (v < -32768)
            v = -32768;
        return v[15:0];
    endfunction

    function automatic logic [63:0] ref_samples(
        input logic [63:0] adc,
        input logic [31:0] t0,
        input logic [31:0] t1,
        input logic        swap,
        input logic        mute,
        input logic        loop,
        input int          g
    );
        logic [31:0] a0;
        logic [31:0] a1;
        a0 = swap ? adc[63:32] : adc[31:0];
        a1 = swap ? adc[31:0] : adc[63:32];
        if (mute)
            a0 = '0;
        if (loop)
        begin
            a0 = t0;
            a1 = t1;
        end
        // antenna words are {q, i}, demodulator takes {i, q}
        return {sat_gain(a1[15:0], g), sat_gain(a1[31:16], g),
                sat_gain(a0[15:0], g), sat_gain(a0[31:16], g)};
    endfunction

    // little endian, byte n of a word lands at bits 8n+7:8n
    function automatic logic [63:0] place_byte(input logic [63:0] w, input int n,
                                               input logic [7:0] b);
        logic [63:0] r;
        r = w;
        r[8*n +: 8] = b;
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    always @(posedge clk)
    begin : model
        logic [63:0] exp_v;
        int          exp_c;
        cyc = cyc + 1;
        if (reset)
        begin
            exp_samples.delete();
            sample_cyc.delete();
            exp_words.delete();
            word_cyc.delete();
            word_acc = '0;
            nbytes = 0;
            exp_intr = 1'b0;
            exp_sn = '0;
            exp_good = '0;
            exp_bad = '0;
            exp_led = 1'b0;
        end
        else
        begin
            // outputs still show what the previous edge produced
            if (sample_strobe && exp_samples.size() == 0)
            begin
                errors++;
                $display("sample_strobe pulsed with no sample in flight at cycle %0d", cyc);
            end
            else if (sample_strobe)
            begin
                exp_v = exp_samples.pop_front();
                exp_c = sample_cyc.pop_front();
                compare_value("sample0", sample0, exp_v[31:0]);
                compare_value("sample1", sample1, exp_v[63:32]);
                compare_value("sample_strobe latency", cyc - exp_c, strobe_delay_sel ? 4 : 3);
            end
            if (word_strobe && exp_words.size() == 0)
            begin
                errors++;
                $display("word_strobe pulsed with no word expected at cycle %0d", cyc);
            end
            else if (word_strobe)
            begin
                exp_v = exp_words.pop_front();
                exp_c = word_cyc.pop_front();
                compare_value("word_out", word_out, exp_v);
                compare_value("word_strobe latency", cyc - exp_c, 1);
            end
            compare_value("rx_pkt_intr", rx_pkt_intr, exp_intr);
            compare_value("rx_pkt_sn", rx_pkt_sn, exp_sn);
            compare_value("good_count", good_count, exp_good);
            compare_value("bad_count", bad_count, exp_bad);
            compare_value("fcs_ok_led", fcs_ok_led, exp_led);

            if (loopback_en ? tx_iq_valid : adc_valid)
            begin
                exp_samples.push_back(ref_samples(adc_data.raw, tx_iq0, tx_iq1, ant_swap,
                                                  mute_ant0, loopback_en, int'(bb_gain)));
                sample_cyc.push_back(cyc);
            end

            if (pkt_header_valid_strobe)
            begin
                word_acc = '0;
                nbytes = 0;
            end
            else if (byte_in_strobe)
            begin
                word_acc = place_byte(word_acc, nbytes, byte_in);
                nbytes++;
            end
            // full word, or the padded rest at the frame check
            if (nbytes == 8 || (fcs_in_strobe && nbytes != 0))
            begin
                exp_words.push_back(word_acc);
                word_cyc.push_back(cyc);
                word_acc = '0;
                nbytes = 0;
            end

            exp_intr = fcs_in_strobe & (fcs_ok | intr_on_any_fcs);
            if (fcs_in_strobe)
            begin
                exp_sn++;
                if (fcs_ok)
                begin
                    exp_good++;
                    exp_led = ~exp_led;
                end
                else
                    exp_bad++;
            end
        end
        pending = exp_samples.size() + exp_words.size();
    end

endmodule

// File: bench/rx_front_clkgen.sv
// rx_front_clkgen: 8 ns testbench clock and a two-cycle synchronous reset
`timescale 1ns/1ps

module rx_front_clkgen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // released on a falling edge, in step with the stimulus
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: src/rx_front.sv
// rx_front: receive front end, sample path to the demodulator and payload/status path
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_front (
    input  logic                       clk,
    input  logic                       reset,
    // ADC and tx loopback samples
    input  rx_front_pkg::adc_word_u    adc_data,
    input  logic                       adc_valid,
    input  rx_front_pkg::iq_sample_t   tx_iq0,
    input  rx_front_pkg::iq_sample_t   tx_iq1,
    input  logic                       tx_iq_valid,
    // configuration levels
    input  logic                       ant_swap,
    input  logic                       mute_ant0,
    input  logic                       loopback_en,
    input  logic [`GAIN_WIDTH-1:0]     bb_gain,
    input  logic                       strobe_delay_sel,
    input  logic                       intr_on_any_fcs,
    // to the demodulator
    output logic [2*`IQ_WIDTH-1:0]     sample0,
    output logic [2*`IQ_WIDTH-1:0]     sample1,
    output logic                       sample_strobe,
    // from the decoder
    input  logic [7:0]                 byte_in,
    input  logic                       byte_in_strobe,
    input  logic                       pkt_header_valid_strobe,
    input  logic                       fcs_in_strobe,
    input  logic                       fcs_ok,
    // packed payload and packet status
    output logic [`PKT_WORD_WIDTH-1:0] word_out,
    output logic                       word_strobe,
    output logic                       rx_pkt_intr,
    output logic [`PKT_CNT_WIDTH-1:0]  rx_pkt_sn,
    output logic [`PKT_CNT_WIDTH-1:0]  good_count,
    output logic [`PKT_CNT_WIDTH-1:0]  bad_count,
    output logic                       fcs_ok_led
);

    rx_front_pkg::iq_sample_t [`NUM_ANT-1:0] lane_iq;
    logic                                    lane_valid;
    rx_front_pkg::iq_sample_t [`NUM_ANT-1:0] gain_iq;
    logic [`NUM_ANT-1:0]                     gain_valid;

    rx_sample_select u_select (
        .clk         (clk),
        .reset       (reset),
        .adc_data    (adc_data),
        .adc_valid   (adc_valid),
        .tx_iq0      (tx_iq0),
        .tx_iq1      (tx_iq1),
        .tx_iq_valid (tx_iq_valid),
        .ant_swap    (ant_swap),
        .mute_ant0   (mute_ant0),
        .loopback_en (loopback_en),
        .lane_iq     (lane_iq),
        .lane_valid  (lane_valid)
    );

    // one gain lane per antenna
    for (genvar k = 0; k < `NUM_ANT; k++)
    begin : g_lane
        rx_gain_lane u_lane (
            .clk          (clk),
            .reset        (reset),
            .iq_in        (lane_iq[k]),
            .iq_valid     (lane_valid),
            .bb_gain      (bb_gain),
            .iq_out       (gain_iq[k]),
            .iq_out_valid (gain_valid[k])
        );
    end

    rx_sample_align u_align (
        .clk              (clk),
        .reset            (reset),
        .gain_iq          (gain_iq),
        .gain_valid       (gain_valid),
        .strobe_delay_sel (strobe_delay_sel),
        .sample0          (sample0),
        .sample1          (sample1),
        .sample_strobe    (sample_strobe)
    );

    rx_byte_packer u_packer (
        .clk                     (clk),
        .reset                   (reset),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .word_out                (word_out),
        .word_strobe             (word_strobe)
    );

    rx_pkt_status u_status (
        .clk             (clk),
        .reset           (reset),
        .fcs_in_strobe   (fcs_in_strobe),
        .fcs_ok          (fcs_ok),
        .intr_on_any_fcs (intr_on_any_fcs),
        .rx_pkt_intr     (rx_pkt_intr),
        .rx_pkt_sn       (rx_pkt_sn),
        .good_count      (good_count),
        .bad_count       (bad_count),
        .fcs_ok_led      (fcs_ok_led)
    );

endmodule

// File: src/rx_pkt_status.sv
// rx_pkt_status: fcs strobe decode into interrupt, sequence number, frame counters and led
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_pkt_status (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fcs_in_strobe,
    input  logic                      fcs_ok,
    input  logic                      intr_on_any_fcs,
    output logic                      rx_pkt_intr,
    output logic [`PKT_CNT_WIDTH-1:0] rx_pkt_sn,
    output logic [`PKT_CNT_WIDTH-1:0] good_count,
    output logic [`PKT_CNT_WIDTH-1:0] bad_count,
    output logic                      fcs_ok_led
);

    logic fcs_valid;
    logic fcs_invalid;
    logic intr_src;

    assign fcs_valid   = fcs_in_strobe & fcs_ok;
    assign fcs_invalid = fcs_in_strobe & ~fcs_ok;

    // any-fcs mode also raises the interrupt on a bad frame
    assign intr_src = intr_on_any_fcs ? (fcs_valid | fcs_invalid) : fcs_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_pkt_intr <= 1'b0;
            rx_pkt_sn   <= '0;
            good_count  <= '0;
            bad_count   <= '0;
            fcs_ok_led  <= 1'b0;
        end
        else
        begin
            rx_pkt_intr <= intr_src;
            if (fcs_in_strobe)
                rx_pkt_sn <= rx_pkt_sn + 1'b1;
            if (fcs_valid)
            begin
                good_count <= good_count + 1'b1;
                fcs_ok_led <= ~fcs_ok_led;
            end
            if (fcs_invalid)
                bad_count <= bad_count + 1'b1;
        end
    end

endmodule

// File: src/rx_byte_packer.sv
// rx_byte_packer: little-endian packing of payload bytes into words, partial flush at fcs
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_byte_packer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 byte_in,
    input  logic                       byte_in_strobe,
    input  logic                       pkt_header_valid_strobe,
    input  logic                       fcs_in_strobe,
    output logic [`PKT_WORD_WIDTH-1:0] word_out,
    output logic                       word_strobe
);

    localparam int BYTES_PER_WORD = `PKT_WORD_WIDTH / 8;
    localparam int IDX_W          = $clog2(BYTES_PER_WORD);

    logic [IDX_W-1:0]           byte_idx;
    logic [`PKT_WORD_WIDTH-1:0] word_acc;
    logic                       byte_take;

    // header strobe wins over a byte
    assign byte_take = byte_in_strobe & ~pkt_header_valid_strobe;

    // first byte of a word clears the rest, so a flush is zero padded
    always_ff @(posedge clk)
    begin
        if (byte_take)
        begin
            if (byte_idx == '0)
                word_acc <= {{(`PKT_WORD_WIDTH-8){1'b0}}, byte_in};
            else
                word_acc[{byte_idx, 3'b000} +: 8] <= byte_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_idx    <= '0;
            word_strobe <= 1'b0;
        end
        else
        begin
            word_strobe <= 1'b0;
            if (pkt_header_valid_strobe)
                byte_idx <= '0;
            else if (byte_in_strobe)
            begin
                // index wraps to 0 after the last byte
                byte_idx <= byte_idx + 1'b1;
                if (byte_idx == IDX_W'(BYTES_PER_WORD - 1))
                    word_strobe <= 1'b1;
            end
            else if (fcs_in_strobe && byte_idx != '0)
            begin
                byte_idx    <= '0;
                word_strobe <= 1'b1;
            end
        end
    end

    assign word_out = word_acc;

endmodule

// File: src/rx_sample_align.sv
// rx_sample_align: i-high demodulator sample layout with an optional extra strobe cycle
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_sample_align (
    input  logic                                    clk,
    input  logic                                    reset,
    input  rx_front_pkg::iq_sample_t [`NUM_ANT-1:0] gain_iq,
    input  logic [`NUM_ANT-1:0]                     gain_valid,
    input  logic                                    strobe_delay_sel,
    output logic [2*`IQ_WIDTH-1:0]                  sample0,
    output logic [2*`IQ_WIDTH-1:0]                  sample1,
    output logic                                    sample_strobe
);

    logic [`NUM_ANT-1:0][2*`IQ_WIDTH-1:0] stage1;
    logic [`NUM_ANT-1:0][2*`IQ_WIDTH-1:0] stage2;
    logic                                 strobe1;
    logic                                 strobe2;

    // demodulator wants i on top
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < `NUM_ANT; k++)
        begin
            stage1[k] <= {gain_iq[k].i, gain_iq[k].q};
        end
        stage2 <= stage1;
    end

    // lanes run in lock step, lane 0 stands for both
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            strobe1 <= 1'b0;
            strobe2 <= 1'b0;
        end
        else
        begin
            strobe1 <= gain_valid[0];
            strobe2 <= strobe1;
        end
    end

    assign sample0       = strobe_delay_sel ? stage2[0] : stage1[0];
    assign sample1       = strobe_delay_sel ? stage2[1] : stage1[1];
    assign sample_strobe = strobe_delay_sel ? strobe2 : strobe1;

endmodule

// File: src/rx_gain_lane.sv
// rx_gain_lane: saturating left-shift gain on one antenna's I/Q pair
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_gain_lane (
    input  logic                     clk,
    input  logic                     reset,
    input  rx_front_pkg::iq_sample_t iq_in,
    input  logic                     iq_valid,
    input  logic [`GAIN_WIDTH-1:0]   bb_gain,
    output rx_front_pkg::iq_sample_t iq_out,
    output logic                     iq_out_valid
);

    // headroom for the largest shift
    localparam int EXT_W  = (1 << `GAIN_WIDTH) - 1;
    localparam int WIDE_W = `IQ_WIDTH + EXT_W;

    function automatic logic signed [`IQ_WIDTH-1:0] sat_shift(
        input logic signed [`IQ_WIDTH-1:0] x,
        input logic [`GAIN_WIDTH-1:0]      sh
    );
        logic signed [WIDE_W-1:0]    wide;
        logic signed [`IQ_WIDTH-1:0] result;
        wide = {{EXT_W{x[`IQ_WIDTH-1]}}, x};
        wide = wide <<< sh;
        // fits when all bits above the kept sign agree with it
        if (&wide[WIDE_W-1:`IQ_WIDTH-1] || ~|wide[WIDE_W-1:`IQ_WIDTH-1])
            result = wide[`IQ_WIDTH-1:0];
        else if (wide[WIDE_W-1])
            result = {1'b1, {(`IQ_WIDTH-1){1'b0}}};
        else
            result = {1'b0, {(`IQ_WIDTH-1){1'b1}}};
        return result;
    endfunction

    always_ff @(posedge clk)
    begin
        iq_out.i <= sat_shift(iq_in.i, bb_gain);
        iq_out.q <= sat_shift(iq_in.q, bb_gain);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            iq_out_valid <= 1'b0;
        else
            iq_out_valid <= iq_valid;
    end

endmodule

// File: src/rx_sample_select.sv
// rx_sample_select: antenna swap, antenna 0 mute and tx loopback ahead of the gain lanes
`timescale 1ns/1ps
`include "rx_front_defs.svh"

module rx_sample_select (
    input  logic                                    clk,
    input  logic                                    reset,
    input  rx_front_pkg::adc_word_u                 adc_data,
    input  logic                                    adc_valid,
    input  rx_front_pkg::iq_sample_t                tx_iq0,
    input  rx_front_pkg::iq_sample_t                tx_iq1,
    input  logic                                    tx_iq_valid,
    input  logic                                    ant_swap,
    input  logic                                    mute_ant0,
    input  logic                                    loopback_en,
    output rx_front_pkg::iq_sample_t [`NUM_ANT-1:0] lane_iq,
    output logic                                    lane_valid
);

    rx_front_pkg::adc_word_u sel_word;
    rx_front_pkg::adc_word_u lane_word;

    always_comb
    begin
        sel_word.raw = adc_data.raw;
        if (ant_swap)
        begin
            sel_word.ant[0] = adc_data.ant[1];
            sel_word.ant[1] = adc_data.ant[0];
        end
        // mute applies after the swap
        if (mute_ant0)
            sel_word.ant[0] = '0;
        // loopback overrides swap and mute
        if (loopback_en)
            sel_word.raw = {tx_iq1, tx_iq0};
    end

    always_ff @(posedge clk)
    begin
        lane_word <= sel_word;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lane_valid <= 1'b0;
        else
            lane_valid <= loopback_en ? tx_iq_valid : adc_valid;
    end

    assign lane_iq = lane_word.ant;

endmodule

// File: src/rx_front_pkg.sv
// rx_front_pkg: I/Q sample type and the two views of a packed ADC word
`include "rx_front_defs.svh"

package rx_front_pkg;

    // q in the upper half, i in the lower half
    typedef struct packed {
        logic signed [`IQ_WIDTH-1:0] q;
        logic signed [`IQ_WIDTH-1:0] i;
    } iq_sample_t;

    // raw word as it arrives, or split per antenna
    // antenna 0 sits in the low half
    typedef union packed {
        logic [`ADC_WORD_WIDTH-1:0]         raw;
        iq_sample_t [`NUM_ANT-1:0]          ant;
    } adc_word_u;

endpackage

// File: src/rx_front_defs.svh
// rx_front widths: sample, ADC word, gain, packed payload word and counter sizes
`ifndef RX_FRONT_DEFS_SVH
`define RX_FRONT_DEFS_SVH

// one signed I or Q value
`define IQ_WIDTH 16

// packed ADC word, two antennas of I/Q
`define ADC_WORD_WIDTH 64
`define NUM_ANT 2

// baseband gain as a left shift, 0 to 7
`define GAIN_WIDTH 3

// payload words and packet counters
`define PKT_WORD_WIDTH 64
`define PKT_CNT_WIDTH 16

`endif
